// File: common/uart_alu_pkg.sv
`default_nettype none

package uart_alu_pkg;

	//////////////////////
	// frame constants
	//////////////////////
	localparam int NBIT_DATA     = 8;   // data bits per frame
	localparam int NUM_TICKS     = 16;  // oversampling ticks per bit
	localparam int CLKS_PER_TICK = 4;   // clk cycles between baud ticks

	localparam int TICK_CNT_W = $clog2(NUM_TICKS);
	localparam int BIT_CNT_W  = $clog2(NBIT_DATA);
	localparam int DIV_CNT_W  = $clog2(CLKS_PER_TICK);

	// counter compare values, sized to the counters
	localparam logic [TICK_CNT_W-1:0] TICK_LAST = TICK_CNT_W'(NUM_TICKS - 1);
	localparam logic [TICK_CNT_W-1:0] TICK_MID  = TICK_CNT_W'(NUM_TICKS / 2 - 1);
	localparam logic [BIT_CNT_W-1:0]  BIT_LAST  = BIT_CNT_W'(NBIT_DATA - 1);
	localparam logic [DIV_CNT_W-1:0]  DIV_LAST  = DIV_CNT_W'(CLKS_PER_TICK - 1);

	typedef logic [NBIT_DATA-1:0] data_t;

	//////////////////////
	// alu opcodes
	//////////////////////
	typedef enum logic [7:0] {
		op_add = 8'h20,
		op_sub = 8'h22,
		op_and = 8'h24,
		op_or  = 8'h25,
		op_xor = 8'h26,
		op_nor = 8'h27,
		op_srl = 8'h02,
		op_sra = 8'h03
	} opcode_e;

	typedef struct packed {
		data_t   operand_a;
		data_t   operand_b;
		opcode_e opcode;   // may hold a byte outside the enum
	} alu_request_t;

	//////////////////////
	// fsm states
	//////////////////////
	typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_e;
	typedef enum logic [1:0] {tx_idle, tx_start, tx_data, tx_stop} tx_state_e;
	typedef enum logic [1:0] {wait_a, wait_b, wait_op, send} if_state_e;

endpackage

`default_nettype wire

// File: verilog/baud_rate_gen.sv
`timescale 1ns/1ps
`default_nettype none

module baud_rate_gen (
	input  wire  clk,
	input  wire  arst_n,
	output logic tick    // one clk wide, every CLKS_PER_TICK clocks
);

	import uart_alu_pkg::*;

	logic [DIV_CNT_W-1:0] div_cnt;

	// free running divider, tick registered on the wrap
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			div_cnt <= '0;
			tick    <= 1'b0;
		end
		else
		begin
			tick <= (div_cnt == DIV_LAST);
			if (div_cnt == DIV_LAST)
				div_cnt <= '0;   // wrap
			else
				div_cnt <= div_cnt + 1'b1;
		end
	end

	// divider must be at least 2 for rx/tx pulses to stay single cycle
	a_tick_single: assert property (
		@(posedge clk) disable iff (!arst_n)
		tick |=> !tick
	) else $error("baud tick high on two consecutive clocks");

endmodule

`default_nettype wire

// File: uart/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
	input  wire                 clk,
	input  wire                 arst_n,
	input  wire                 tick,
	input  wire                 rx,
	output uart_alu_pkg::data_t rx_data,       // last complete byte
	output logic                rx_done_tick
);

	import uart_alu_pkg::*;

	rx_state_e             state;
	logic [TICK_CNT_W-1:0] tick_cnt;
	logic [BIT_CNT_W-1:0]  bit_cnt;
	data_t                 shreg;   // assembly register, LSB arrives first
	logic                  rx_meta;
	logic                  rx_sync;

	//////////////////////
	// input synchronizer
	//////////////////////
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			rx_meta <= 1'b1;   // line idles high
			rx_sync <= 1'b1;
		end
		else
		begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	//////////////////////
	// receive fsm
	//////////////////////
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state        <= rx_idle;
			tick_cnt     <= '0;
			bit_cnt      <= '0;
			rx_done_tick <= 1'b0;
		end
		else
		begin
			rx_done_tick <= 1'b0;
			case (state)
				rx_idle:
				begin
					if (!rx_sync)   // falling edge, maybe a start bit
					begin
						state    <= rx_start;
						tick_cnt <= '0;
					end
				end
				rx_start:
				begin
					if (tick)
					begin
						if (tick_cnt == TICK_MID)
						begin
							tick_cnt <= '0;
							bit_cnt  <= '0;
							// glitch check at mid start bit
							state    <= rx_sync ? rx_idle : uart_alu_pkg::rx_data;
						end
						else
							tick_cnt <= tick_cnt + 1'b1;
					end
				end
				uart_alu_pkg::rx_data:
				begin
					if (tick)
					begin
						if (tick_cnt == TICK_LAST)   // centre of a data bit
						begin
							tick_cnt <= '0;
							if (bit_cnt == BIT_LAST)
								state <= rx_stop;
							else
								bit_cnt <= bit_cnt + 1'b1;
						end
						else
							tick_cnt <= tick_cnt + 1'b1;
					end
				end
				rx_stop:
				begin
					if (tick)
					begin
						if (tick_cnt == TICK_LAST)
						begin
							state        <= rx_idle;
							tick_cnt     <= '0;
							rx_done_tick <= 1'b1;   // stop bit not checked
						end
						else
							tick_cnt <= tick_cnt + 1'b1;
					end
				end
				default: state <= rx_idle;
			endcase
		end
	end

	// payload path, shifts at the bit centres
	always_ff @(posedge clk)
	begin
		if (state == uart_alu_pkg::rx_data && tick && tick_cnt == TICK_LAST)
			shreg <= {rx_sync, shreg[NBIT_DATA-1:1]};
		if (state == rx_stop && tick && tick_cnt == TICK_LAST)
			rx_data <= shreg;   // held until the next frame ends
	end

	a_rx_done_pulse: assert property (
		@(posedge clk) disable iff (!arst_n)
		rx_done_tick |=> !rx_done_tick
	) else $error("rx_done_tick wider than one clock");

endmodule

`default_nettype wire

// File: uart/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
	input  wire                 clk,
	input  wire                 arst_n,
	input  wire                 tick,
	input  wire                 tx_start,       // level, sampled on tick in idle
	input  uart_alu_pkg::data_t tx_data,
	output logic                tx_done_tick,
	output logic                tx
);

	import uart_alu_pkg::*;

	tx_state_e             state;
	logic [TICK_CNT_W-1:0] tick_cnt;
	logic [BIT_CNT_W-1:0]  bit_cnt;
	data_t                 buffer;   // shifted right, bit 0 goes out next

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state        <= tx_idle;
			tick_cnt     <= '0;
			bit_cnt      <= '0;
			tx           <= 1'b1;
			tx_done_tick <= 1'b0;
		end
		else
		begin
			tx_done_tick <= 1'b0;
			if (tick)
			begin
				case (state)
					tx_idle:
					begin
						if (tx_start)
						begin
							state    <= uart_alu_pkg::tx_start;
							tick_cnt <= '0;
							tx       <= 1'b0;   // start bit goes out now
						end
					end
					uart_alu_pkg::tx_start:
					begin
						if (tick_cnt == TICK_LAST)
						begin
							state    <= uart_alu_pkg::tx_data;
							tick_cnt <= '0;
							bit_cnt  <= '0;
							tx       <= buffer[0];   // first data bit, LSB
						end
						else
							tick_cnt <= tick_cnt + 1'b1;
					end
					uart_alu_pkg::tx_data:
					begin
						if (tick_cnt == TICK_LAST)
						begin
							tick_cnt <= '0;
							if (bit_cnt == BIT_LAST)
							begin
								state <= tx_stop;
								tx    <= 1'b1;   // stop bit
							end
							else
							begin
								bit_cnt <= bit_cnt + 1'b1;
								tx      <= buffer[1];   // next bit, before shift
							end
						end
						else
							tick_cnt <= tick_cnt + 1'b1;
					end
					tx_stop:
					begin
						if (tick_cnt == TICK_LAST)
						begin
							state        <= tx_idle;
							tick_cnt     <= '0;
							tx_done_tick <= 1'b1;
						end
						else
							tick_cnt <= tick_cnt + 1'b1;
					end
					default: state <= tx_idle;
				endcase
			end
		end
	end

	// shift buffer, payload only
	always_ff @(posedge clk)
	begin
		if (tick && state == tx_idle && tx_start)
			buffer <= tx_data;
		else if (tick && state == uart_alu_pkg::tx_data && tick_cnt == TICK_LAST)
			buffer <= buffer >> 1;
	end

	a_tx_idle_high: assert property (
		@(posedge clk) disable iff (!arst_n)
		(state == tx_idle) |-> tx
	) else $error("tx line low while idle");

	a_tx_done_pulse: assert property (
		@(posedge clk) disable iff (!arst_n)
		tx_done_tick |=> !tx_done_tick
	) else $error("tx_done_tick wider than one clock");

endmodule

`default_nettype wire

// File: verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  uart_alu_pkg::alu_request_t request,
	output uart_alu_pkg::data_t        result
);

	import uart_alu_pkg::*;

	data_t            a;
	data_t            b;
	logic [2:0]       shamt;   // only low 3 bits of B shift
	logic signed [NBIT_DATA-1:0] a_signed;

	assign a        = request.operand_a;
	assign b        = request.operand_b;
	assign shamt    = b[2:0];
	assign a_signed = a;

	//////////////////////
	// opcode decode
	//////////////////////
	always_comb
	begin
		case (request.opcode)
			op_add: result = a + b;        // mod 256
			op_sub: result = a - b;        // mod 256
			op_and: result = a & b;
			op_or:  result = a | b;
			op_xor: result = a ^ b;
			op_nor: result = ~(a | b);
			op_srl: result = a >> shamt;   // zero fill
			op_sra: result = a_signed >>> shamt;   // sign fill
			default:
				result = '0;   // invalid opcode byte
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/alu_interface.sv
`timescale 1ns/1ps
`default_nettype none

module alu_interface (
	input  wire                        clk,
	input  wire                        arst_n,
	input  uart_alu_pkg::data_t        rx_data,
	input  wire                        rx_done_tick,
	output uart_alu_pkg::alu_request_t request,
	input  uart_alu_pkg::data_t        result,
	output uart_alu_pkg::data_t        tx_data,
	output logic                       tx_start,
	input  wire                        tx_done_tick
);

	import uart_alu_pkg::*;

	if_state_e state;

	//////////////////////
	// command sequencer
	//////////////////////
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state    <= wait_a;
			tx_start <= 1'b0;
		end
		else
		begin
			case (state)
				wait_a:  if (rx_done_tick) state <= wait_b;
				wait_b:  if (rx_done_tick) state <= wait_op;
				wait_op: if (rx_done_tick) state <= send;   // opcode stored same edge
				send:
				begin
					// rx bytes ignored here, they are lost
					if (tx_done_tick)
					begin
						tx_start <= 1'b0;   // drop before the next baud tick
						state    <= wait_a;
					end
					else
						tx_start <= 1'b1;   // result latched this edge too
				end
				default: state <= wait_a;
			endcase
		end
	end

	// operand and result registers
	always_ff @(posedge clk)
	begin
		if (rx_done_tick)
		begin
			case (state)
				wait_a:  request.operand_a <= rx_data;
				wait_b:  request.operand_b <= rx_data;
				wait_op: request.opcode    <= opcode_e'(rx_data);
				default: ;
			endcase
		end
		if (state == send && !tx_start)   // first clock of send
			tx_data <= result;
	end

	a_start_in_send: assert property (
		@(posedge clk) disable iff (!arst_n)
		tx_start |-> (state == send)
	) else $error("tx_start high outside send");

endmodule

`default_nettype wire

// File: verilog/uart_alu_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_alu_top (
	input  wire  clk,
	input  wire  arst_n,
	input  wire  rx,    // serial in, idle high
	output logic tx     // serial out, idle high
);

	import uart_alu_pkg::*;

	logic         tick;
	data_t        rx_data;
	logic         rx_done_tick;
	alu_request_t request;
	data_t        result;
	data_t        tx_data;
	logic         tx_start;
	logic         tx_done_tick;

	baud_rate_gen baud_rate_gen_inst (
		.clk    (clk),
		.arst_n (arst_n),
		.tick   (tick)
	);

	uart_rx uart_rx_inst (
		.clk          (clk),
		.arst_n       (arst_n),
		.tick         (tick),
		.rx           (rx),
		.rx_data      (rx_data),
		.rx_done_tick (rx_done_tick)
	);

	alu_interface alu_interface_inst (
		.clk          (clk),
		.arst_n       (arst_n),
		.rx_data      (rx_data),
		.rx_done_tick (rx_done_tick),
		.request      (request),
		.result       (result),
		.tx_data      (tx_data),
		.tx_start     (tx_start),
		.tx_done_tick (tx_done_tick)
	);

	alu alu_inst (
		.request (request),
		.result  (result)   // combinational
	);

	uart_tx uart_tx_inst (
		.clk          (clk),
		.arst_n       (arst_n),
		.tick         (tick),
		.tx_start     (tx_start),
		.tx_data      (tx_data),
		.tx_done_tick (tx_done_tick),
		.tx           (tx)
	);

endmodule

`default_nettype wire

// File: dv/uart_alu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module uart_alu_tb;

	import uart_alu_pkg::*;

	localparam int CLKS_PER_BIT = NUM_TICKS * CLKS_PER_TICK;   // 64 clocks per bit
	localparam int RX_TIMEOUT   = 2000;                        // clocks to wait for a start edge

	logic clk;
	logic arst_n;
	logic rx;
	logic tx;

	int          data_errors;
	int          level_errors;
	int          length_errors;
	int          timeout_errors;
	logic [31:0] lcg_state;

	uart_alu_top uart_alu_top_inst (
		.clk    (clk),
		.arst_n (arst_n),
		.rx     (rx),
		.tx     (tx)
	);

	always #4 clk = ~clk;   // 8 ns period

	////////////////////
	// helpers
	////////////////////
	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// expected result, straight from the opcode table
	function automatic data_t alu_model(input data_t a, input data_t b, input logic [7:0] op);
		int         wide;
		logic [2:0] sh;
		data_t      ones;
		data_t      fill;
		sh   = b[2:0];
		ones = 8'hff;
		fill = a[7] ? ~(ones >> sh) : 8'h00;   // sign bits shifted in from the top
		case (op)
			8'h20: wide = int'(a) + int'(b);
			8'h22: wide = int'(a) - int'(b) + 256;
			8'h24: wide = int'(a & b);
			8'h25: wide = int'(a | b);
			8'h26: wide = int'(a ^ b);
			8'h27: wide = int'(data_t'(~(a | b)));
			8'h02: wide = int'(a >> sh);
			8'h03: wide = int'((a >> sh) | fill);
			default: wide = 0;   // unknown opcode byte
		endcase
		return data_t'(wide % 256);
	endfunction

	task automatic wait_clocks(input int n);
		repeat (n) @(posedge clk);
		#1;   // drive point
	endtask

	task automatic check_data(input string name, input data_t got, input data_t expected);
		if (got !== expected)
		begin
			data_errors++;
			$display("Error at %0t: %s got 8'h%02h expected 8'h%02h", $time, name, got, expected);
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic expected);
		if (got !== expected)
		begin
			level_errors++;
			$display("Error at %0t: %s got %b expected %b", $time, name, got, expected);
		end
	endtask

	task automatic check_length(input string name, input int got, input int expected, input int tol);
		if (got < expected - tol || got > expected + tol)
		begin
			length_errors++;
			$display("Error at %0t: %s got %0d expected %0d", $time, name, got, expected);
		end
	endtask

	// one 8N1 frame on rx, LSB first
	task automatic send_byte(input data_t value);
		logic [9:0] frame;
		frame = {1'b1, value, 1'b0};   // stop, data, start
		for (int i = 0; i < 10; i++)
		begin
			rx = frame[i];
			wait_clocks(CLKS_PER_BIT);
		end
	endtask

	task automatic receive_byte(output data_t value, output logic stop_bit,
		output int start_len, output logic ok);
		int   waited;
		int   k;
		logic low_run;
		waited    = 0;
		ok        = 1'b0;
		value     = '0;
		stop_bit  = 1'b0;
		start_len = 0;
		while (!ok && waited < RX_TIMEOUT)   // hunt for the start edge
		begin
			@(negedge clk);
			if (tx === 1'b0)
				ok = 1'b1;
			waited++;
		end
		if (!ok)
		begin
			timeout_errors++;
			$display("Timeout: no start bit appeared on tx within %0d clocks", RX_TIMEOUT);
			return;
		end
		low_run = 1'b1;
		for (int c = 0; c <= 9 * CLKS_PER_BIT + CLKS_PER_BIT / 2; c++)
		begin
			if (c > 0)
				@(negedge clk);
			if (low_run && tx === 1'b0)
				start_len++;   // length of the first low run
			else
				low_run = 1'b0;
			if (c >= CLKS_PER_BIT / 2 && (c - CLKS_PER_BIT / 2) % CLKS_PER_BIT == 0)
			begin
				k = (c - CLKS_PER_BIT / 2) / CLKS_PER_BIT;   // bit centre index
				if (k == 0)
					check_level("tx start bit", tx, 1'b0);
				else if (k <= NBIT_DATA)
					value[k-1] = tx;
				else
					stop_bit = tx;
			end
		end
	endtask

	// A, B, opcode out, result back and checked
	task automatic run_op(input data_t a, input data_t b, input logic [7:0] op,
		output int start_len);
		data_t got;
		logic  stop_bit;
		logic  ok;
		send_byte(a);
		send_byte(b);
		fork
			send_byte(data_t'(op));
			receive_byte(got, stop_bit, start_len, ok);   // reply starts inside the stop bit
		join
		wait_clocks(1);   // back on the drive point
		if (ok)
		begin
			check_data($sformatf("tx byte for %02h op %02h %02h", a, op, b), got,
				alu_model(a, b, op));
			check_level("tx stop bit", stop_bit, 1'b1);
		end
	endtask

	task automatic expect_line_idle(input int n, input string name);
		for (int i = 0; i < n; i++)
		begin
			@(negedge clk);
			if (tx !== 1'b1)
			begin
				check_level(name, tx, 1'b1);
				break;
			end
		end
		wait_clocks(1);
	endtask

	////////////////////
	// tests
	////////////////////
	task automatic test_all_opcodes();
		opcode_e op;
		int      len;
		op = op.first();
		for (int i = 0; i < op.num(); i++)
		begin
			run_op(8'hA5, 8'h3C, op, len);
			run_op(8'h0F, 8'hF1, op, len);   // sub wraps here
			op = op.next();
		end
		run_op(8'h96, 8'h00, op_srl, len);   // shift by 0
		run_op(8'h96, 8'h07, op_srl, len);
		run_op(8'h96, 8'hF8, op_sra, len);   // only low 3 bits of B count
		run_op(8'h96, 8'h07, op_sra, len);   // negative A, sign fill
		run_op(8'h6A, 8'h07, op_sra, len);
	endtask

	task automatic test_random_ops();
		data_t a;
		data_t b;
		int    len;
		for (int i = 0; i < 20; i++)
		begin
			a = data_t'(next_random() >> 24);
			b = data_t'(next_random() >> 16);
			run_op(a, b, op_add, len);
			run_op(a, b, op_sub, len);
			run_op(a, b, op_xor, len);
		end
	endtask

	task automatic test_bad_opcode();
		int len;
		run_op(8'h12, 8'h34, 8'h55, len);   // not an opcode
		run_op(8'h12, 8'h34, op_or, len);
	endtask

	task automatic test_frame_shape();
		int len;
		run_op(8'h01, 8'h02, op_add, len);   // result 03, LSB high ends the start run
		check_length("tx start bit length", len, CLKS_PER_BIT, 4);
	endtask

	task automatic test_rx_glitch();
		int len;
		rx = 1'b0;
		wait_clocks(2 * CLKS_PER_TICK);   // 8 clocks low
		rx = 1'b1;
		expect_line_idle(3 * CLKS_PER_BIT, "tx after rx glitch");
		run_op(8'h81, 8'h01, op_sra, len);
		run_op(8'h40, 8'h22, op_sub, len);
	endtask

	initial
	begin
		$timeformat(-9, 0, " ns", 0);
		clk            = 1'b0;
		arst_n         = 1'b0;
		rx             = 1'b1;
		data_errors    = 0;
		level_errors   = 0;
		length_errors  = 0;
		timeout_errors = 0;
		lcg_state      = 32'h9391_cd9b;
		repeat (10) @(posedge clk);
		#1;
		arst_n = 1'b1;

		expect_line_idle(200, "tx after reset");
		test_all_opcodes();
		test_random_ops();
		test_bad_opcode();
		test_frame_shape();
		test_rx_glitch();

		$display("errors: data %0d, level %0d, length %0d, timeout %0d",
			data_errors, level_errors, length_errors, timeout_errors);
		if (data_errors + level_errors + length_errors + timeout_errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
common/uart_alu_pkg.sv
verilog/baud_rate_gen.sv
uart/uart_rx.sv
uart/uart_tx.sv
verilog/alu.sv
verilog/alu_interface.sv
verilog/uart_alu_top.sv
dv/uart_alu_tb.sv

// File: Bender.yml
package:
  name: uart_alu

sources:
  - common/uart_alu_pkg.sv
  - verilog/baud_rate_gen.sv
  - uart/uart_rx.sv
  - uart/uart_tx.sv
  - verilog/alu.sv
  - verilog/alu_interface.sv
  - verilog/uart_alu_top.sv
  - target: test
    files:
      - dv/uart_alu_tb.sv
